/* tb/decodeStage_golden.txt */
// instrD pcD pcPlus4D regWriteW rdW resultW flushE | rd1E rd2E immExtE ctrl regs haz
// ctrl = {regWr,memWr,jump,branch,aluSrc,loadByte,resSrc[1:0],alu[2:0]} regs = {rs1,rs2,rd}
00000000 00000100 00000104 1 01 11111111 0 00000000 00000000 00000000 000 0000 000
00000000 00000104 00000108 1 02 80000002 0 00000000 00000000 00000000 000 0000 000
00000000 00000108 0000010c 1 03 0000007b 0 00000000 00000000 00000000 000 0000 000
00000000 0000010c 00000110 1 00 deadbeef 0 00000000 00000000 00000000 000 0000 000
002082b3 00000110 00000114 0 00 00000000 0 11111111 80000002 00000002 400 0445 022
40118333 00000114 00000118 0 00 00000000 0 0000007b 11111111 00000401 401 0c26 061
0000f3b3 00000118 0000011c 0 00 00000000 0 11111111 00000000 00000000 402 0407 020
00316433 0000011c 00000120 0 00 00000000 0 80000002 0000007b 00000003 403 0868 043
0020a4b3 00000120 00000124 0 00 00000000 0 11111111 80000002 00000002 405 0449 022
00120533 00000124 00000128 1 04 cafef00d 0 cafef00d 11111111 00000001 400 102a 081
fff20593 00000128 0000012c 0 00 00000000 0 cafef00d 00000000 ffffffff 440 13eb 09f
7f00f613 0000012c 00000130 0 00 00000000 0 11111111 00000000 000007f0 442 060c 030
12316693 00000130 00000134 0 00 00000000 0 80000002 0000007b 00000123 443 086d 043
8001a713 00000134 00000138 0 00 00000000 0 0000007b 00000000 fffff800 445 0c0e 060
00812783 00000138 0000013c 0 00 00000000 0 80000002 00000000 00000008 448 090f 048
ffc08803 0000013c 00000140 0 00 00000000 0 11111111 00000000 fffffffc 468 0790 03c
fe312a23 00000140 00000144 0 00 00000000 0 80000002 0000007b fffffff4 240 0874 043
00208863 00000144 00000148 0 00 00000000 0 11111111 80000002 00000010 081 0450 022
fe018ce3 00000148 0000014c 0 00 00000000 0 0000007b 00000000 fffffff8 081 0c19 060
001000ef 0000014c 00000150 0 00 00000000 0 00000000 11111111 00000800 510 0021 001
ffdff06f 00000150 00000154 0 00 00000000 0 00000000 00000000 fffffffc 510 7fa0 3fd
002082b3 00000154 00000158 0 00 00000000 1 00000000 00000000 00000000 000 0000 022
00316433 00000158 0000015c 0 00 00000000 0 80000002 0000007b 00000003 403 0868 043
000008b3 0000015c 00000160 1 00 12345678 0 00000000 00000000 00000000 400 0011 000
ffffffff 00000160 00000164 0 00 00000000 0 00000000 00000000 ffffffff 000 7fff 3ff

/* decodeStage.f */
rtl/riscvPkg.sv
rtl/ctrlIf.sv
rtl/controlUnit.sv
rtl/immExtender.sv
rtl/registerFile.sv
rtl/decodePipeReg.sv
rtl/decodeStage.sv
tb/decodeChecker.sv
tb/decodeStage_assert.sv
tb/decodeStage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --assert -f decodeStage.f --top-module decodeStage_tb -o simv \
   && ./obj_dir/simv 2>&1 | tee sim.log \
   || { echo "build or simulation failed"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

/* tb/decodeStage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage_tb;

   localparam int NumVec    = 25;
   localparam int Cols      = 13;
   localparam int CycleLimit = NumVec + 2 + 20;

   logic        clk;
   logic        rst;
   logic [31:0] instrD;
   logic [31:0] pcD;
   logic [31:0] pcPlus4D;
   logic [31:0] resultW;
   logic        regWriteW;
   logic [4:0]  rdW;
   logic        flushE;

   logic [31:0] rd1E;
   logic [31:0] rd2E;
   logic [31:0] pcE;
   logic [31:0] pcPlus4E;
   logic [31:0] immExtE;
   logic [4:0]  rs1E;
   logic [4:0]  rs2E;
   logic [4:0]  rdE;
   logic        regWriteE;
   logic        memWriteE;
   logic        jumpE;
   logic        branchE;
   logic        aluSrcE;
   logic        loadByteE;
   riscvPkg::resultSrcT resultSrcE;
   riscvPkg::aluCtrlT   aluControlE;
   logic [4:0]  rs1DH;
   logic [4:0]  rs2DH;

   // expected values for the edge that follows the vector
   logic        expValid;
   logic [31:0] expRd1;
   logic [31:0] expRd2;
   logic [31:0] expImm;
   logic [31:0] expCtrl;
   logic [31:0] expRegs;
   logic [31:0] expHaz;

   logic [31:0] golden [0:NumVec*Cols-1];
   int          errorCount;
   int          checkCount;
   int          cycles;

   decodeStage #(
      .WriteThrough (1'b1)
   ) dut (
      .clk (clk), .rst (rst), .instrD (instrD), .pcD (pcD), .pcPlus4D (pcPlus4D),
      .resultW (resultW), .regWriteW (regWriteW), .rdW (rdW), .flushE (flushE),
      .rd1E (rd1E), .rd2E (rd2E), .pcE (pcE), .pcPlus4E (pcPlus4E), .immExtE (immExtE),
      .rs1E (rs1E), .rs2E (rs2E), .rdE (rdE), .regWriteE (regWriteE),
      .memWriteE (memWriteE), .jumpE (jumpE), .branchE (branchE), .aluSrcE (aluSrcE),
      .loadByteE (loadByteE), .resultSrcE (resultSrcE), .aluControlE (aluControlE),
      .rs1DH (rs1DH), .rs2DH (rs2DH)
   );

   decodeChecker uChecker (
      .clk (clk), .rst (rst), .expValid (expValid), .pcD (pcD), .pcPlus4D (pcPlus4D),
      .flushE (flushE), .expRd1 (expRd1), .expRd2 (expRd2), .expImm (expImm),
      .expCtrl (expCtrl), .expRegs (expRegs), .expHaz (expHaz),
      .rd1E (rd1E), .rd2E (rd2E), .pcE (pcE), .pcPlus4E (pcPlus4E), .immExtE (immExtE),
      .rs1E (rs1E), .rs2E (rs2E), .rdE (rdE), .regWriteE (regWriteE),
      .memWriteE (memWriteE), .jumpE (jumpE), .branchE (branchE), .aluSrcE (aluSrcE),
      .loadByteE (loadByteE), .resultSrcE (resultSrcE), .aluControlE (aluControlE),
      .rs1DH (rs1DH), .rs2DH (rs2DH), .errorCount (errorCount), .checkCount (checkCount)
   );

   always #5 clk = ~clk;

   // run limit, counted in rising edges
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CycleLimit) begin
         $display("timeout: the vectors did not finish within %0d cycles", CycleLimit);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic applyVector(input int idx);
      int base;
      base      = idx * Cols;
      instrD    = golden[base];
      pcD       = golden[base + 1];
      pcPlus4D  = golden[base + 2];
      regWriteW = golden[base + 3][0];
      rdW       = golden[base + 4][4:0];
      resultW   = golden[base + 5];
      flushE    = golden[base + 6][0];
      expRd1    = golden[base + 7];
      expRd2    = golden[base + 8];
      expImm    = golden[base + 9];
      expCtrl   = golden[base + 10];
      expRegs   = golden[base + 11];
      expHaz    = golden[base + 12];
      expValid  = 1'b1;
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      instrD = '0;
      pcD = '0;
      pcPlus4D = '0;
      resultW = '0;
      regWriteW = 1'b0;
      rdW = '0;
      flushE = 1'b0;
      expValid = 1'b0;
      expRd1 = '0;
      expRd2 = '0;
      expImm = '0;
      expCtrl = '0;
      expRegs = '0;
      expHaz = '0;
      cycles = 0;
      $readmemh("tb/decodeStage_golden.txt", golden);
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < NumVec; i++) begin
         applyVector(i);
         @(negedge clk);
      end
      expValid = 1'b0;
      regWriteW = 1'b0;
      flushE = 1'b0;
      @(negedge clk);
      $display("errors: %0d, checks: %0d", errorCount, checkCount);
      if (errorCount == 0 && checkCount > 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/decodeStage_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage_assert (
   input wire logic                              clk,
   input wire logic                              rst,
   input wire logic                              flushE,
   input wire logic                              regWriteE,
   input wire logic                              memWriteE,
   input wire logic                              jumpE,
   input wire logic                              branchE,
   input wire logic [riscvPkg::RegAddrWidth-1:0] rs1E,
   input wire logic [riscvPkg::WordWidth-1:0]    rd1E
);

   // a flushed slot carries no side effects
   flushGivesBubble: assert property (@(posedge clk) disable iff (rst)
      flushE |=> !(regWriteE || memWriteE || jumpE || branchE))
      else $error("flush left control active in execute");

   // x0 operand always reads zero
   zeroRegReadsZero: assert property (@(posedge clk) disable iff (rst)
      (rs1E == '0) |-> (rd1E == '0))
      else $error("rs1E is x0 but rd1E is nonzero");

   storeHasNoWriteback: assert property (@(posedge clk) disable iff (rst)
      memWriteE |-> !regWriteE)
      else $error("store with register write enabled");

endmodule

bind decodePipeReg decodeStage_assert uAssert (
   .clk (clk), .rst (rst), .flushE (flushE), .regWriteE (regWriteE),
   .memWriteE (memWriteE), .jumpE (jumpE), .branchE (branchE),
   .rs1E (rs1E), .rd1E (rd1E)
);

`default_nettype wire

/* tb/decodeChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeChecker (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        expValid,
   input  wire logic [31:0] pcD,
   input  wire logic [31:0] pcPlus4D,
   input  wire logic        flushE,
   input  wire logic [31:0] expRd1,
   input  wire logic [31:0] expRd2,
   input  wire logic [31:0] expImm,
   input  wire logic [31:0] expCtrl,
   input  wire logic [31:0] expRegs,
   input  wire logic [31:0] expHaz,
   input  wire logic [31:0] rd1E,
   input  wire logic [31:0] rd2E,
   input  wire logic [31:0] pcE,
   input  wire logic [31:0] pcPlus4E,
   input  wire logic [31:0] immExtE,
   input  wire logic [4:0]  rs1E,
   input  wire logic [4:0]  rs2E,
   input  wire logic [4:0]  rdE,
   input  wire logic        regWriteE,
   input  wire logic        memWriteE,
   input  wire logic        jumpE,
   input  wire logic        branchE,
   input  wire logic        aluSrcE,
   input  wire logic        loadByteE,
   input  riscvPkg::resultSrcT resultSrcE,
   input  riscvPkg::aluCtrlT   aluControlE,
   input  wire logic [4:0]  rs1DH,
   input  wire logic [4:0]  rs2DH,
   output int               errorCount,
   output int               checkCount
);

   initial begin
      errorCount = 0;
      checkCount = 0;
   end

   task automatic compareWord(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checkCount = checkCount + 1;
      if (got !== exp) begin
         errorCount = errorCount + 1;
         $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // vector fields are held from the falling edge, so sample one step after the rise
   always @(posedge clk) begin
      logic [31:0] pcExp;
      logic [31:0] pc4Exp;
      logic        take;
      take   = expValid && !rst;
      pcExp  = flushE ? 32'h0 : pcD;
      pc4Exp = flushE ? 32'h0 : pcPlus4D;
      #1;
      if (take) begin
         compareWord("rd1E", rd1E, expRd1);
         compareWord("rd2E", rd2E, expRd2);
         compareWord("immExtE", immExtE, expImm);
         compareWord("pcE", pcE, pcExp);
         compareWord("pcPlus4E", pcPlus4E, pc4Exp);
         // regWrite memWrite jump branch aluSrc loadByte resultSrc aluControl
         compareWord("ctrlE", {21'b0, regWriteE, memWriteE, jumpE, branchE, aluSrcE,
                     loadByteE, resultSrcE, aluControlE}, expCtrl);
         compareWord("rs1E/rs2E/rdE", {17'b0, rs1E, rs2E, rdE}, expRegs);
         compareWord("rs1DH/rs2DH", {22'b0, rs1DH, rs2DH}, expHaz);
      end
   end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
   parameter bit WriteThrough = 1'b1
) (
   input  wire logic                              clk,
   input  wire logic                              rst,
   input  wire logic [riscvPkg::WordWidth-1:0]    instrD,
   input  wire logic [riscvPkg::WordWidth-1:0]    pcD,
   input  wire logic [riscvPkg::WordWidth-1:0]    pcPlus4D,
   input  wire logic [riscvPkg::WordWidth-1:0]    resultW,
   input  wire logic                              regWriteW,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] rdW,
   input  wire logic                              flushE,
   output logic [riscvPkg::WordWidth-1:0]         rd1E,
   output logic [riscvPkg::WordWidth-1:0]         rd2E,
   output logic [riscvPkg::WordWidth-1:0]         pcE,
   output logic [riscvPkg::WordWidth-1:0]         pcPlus4E,
   output logic [riscvPkg::WordWidth-1:0]         immExtE,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs1E,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs2E,
   output logic [riscvPkg::RegAddrWidth-1:0]      rdE,
   output logic                                   regWriteE,
   output logic                                   memWriteE,
   output logic                                   jumpE,
   output logic                                   branchE,
   output logic                                   aluSrcE,
   output logic                                   loadByteE,
   output riscvPkg::resultSrcT                    resultSrcE,
   output riscvPkg::aluCtrlT                      aluControlE,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs1DH,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs2DH
);

   logic [riscvPkg::RegAddrWidth-1:0] rs1D;
   logic [riscvPkg::RegAddrWidth-1:0] rs2D;
   logic [riscvPkg::RegAddrWidth-1:0] rdD;
   logic [riscvPkg::WordWidth-1:0]    rd1D;
   logic [riscvPkg::WordWidth-1:0]    rd2D;
   logic [riscvPkg::WordWidth-1:0]    immExtD;

   ctrlIf ctrlBus ();

   // register fields of the instruction
   assign rs1D = instrD[19:15];
   assign rs2D = instrD[24:20];
   assign rdD  = instrD[11:7];

   // hazard unit taps, no register in between
   assign rs1DH = rs1D;
   assign rs2DH = rs2D;

   controlUnit uControl (
      .instr (instrD),
      .ctrl  (ctrlBus.ctrlSrc)
   );

   immExtender uImm (
      .instr  (instrD),
      .immSrc (ctrlBus.immSrc),
      .immExt (immExtD)
   );

   registerFile #(
      .WriteThrough (WriteThrough)
   ) uRegFile (
      .clk       (clk),
      .rst       (rst),
      .addr1     (rs1D),
      .addr2     (rs2D),
      .addr3     (rdW),
      .writeEn   (regWriteW),
      .writeData (resultW),
      .readData1 (rd1D),
      .readData2 (rd2D)
   );

   decodePipeReg uPipeReg (
      .clk         (clk),
      .rst         (rst),
      .flushE      (flushE),
      .ctrl        (ctrlBus.ctrlDst),
      .rd1         (rd1D),
      .rd2         (rd2D),
      .pc          (pcD),
      .pcPlus4     (pcPlus4D),
      .immExt      (immExtD),
      .rs1         (rs1D),
      .rs2         (rs2D),
      .rd          (rdD),
      .rd1E        (rd1E),
      .rd2E        (rd2E),
      .pcE         (pcE),
      .pcPlus4E    (pcPlus4E),
      .immExtE     (immExtE),
      .rs1E        (rs1E),
      .rs2E        (rs2E),
      .rdE         (rdE),
      .regWriteE   (regWriteE),
      .memWriteE   (memWriteE),
      .jumpE       (jumpE),
      .branchE     (branchE),
      .aluSrcE     (aluSrcE),
      .loadByteE   (loadByteE),
      .resultSrcE  (resultSrcE),
      .aluControlE (aluControlE)
   );

endmodule

`default_nettype wire

/* rtl/decodePipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

module decodePipeReg (
   input  wire logic                              clk,
   input  wire logic                              rst,
   input  wire logic                              flushE,
   ctrlIf.ctrlDst                                 ctrl,
   input  wire logic [riscvPkg::WordWidth-1:0]    rd1,
   input  wire logic [riscvPkg::WordWidth-1:0]    rd2,
   input  wire logic [riscvPkg::WordWidth-1:0]    pc,
   input  wire logic [riscvPkg::WordWidth-1:0]    pcPlus4,
   input  wire logic [riscvPkg::WordWidth-1:0]    immExt,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] rs1,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] rs2,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] rd,
   output logic [riscvPkg::WordWidth-1:0]         rd1E,
   output logic [riscvPkg::WordWidth-1:0]         rd2E,
   output logic [riscvPkg::WordWidth-1:0]         pcE,
   output logic [riscvPkg::WordWidth-1:0]         pcPlus4E,
   output logic [riscvPkg::WordWidth-1:0]         immExtE,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs1E,
   output logic [riscvPkg::RegAddrWidth-1:0]      rs2E,
   output logic [riscvPkg::RegAddrWidth-1:0]      rdE,
   output logic                                   regWriteE,
   output logic                                   memWriteE,
   output logic                                   jumpE,
   output logic                                   branchE,
   output logic                                   aluSrcE,
   output logic                                   loadByteE,
   output riscvPkg::resultSrcT                    resultSrcE,
   output riscvPkg::aluCtrlT                      aluControlE
);

   logic clearNext;

   // a flushed slot is the same all-zero bubble as reset
   assign clearNext = flushE;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd1E        <= '0;
         rd2E        <= '0;
         pcE         <= '0;
         pcPlus4E    <= '0;
         immExtE     <= '0;
         rs1E        <= '0;
         rs2E        <= '0;
         rdE         <= '0;
         regWriteE   <= 1'b0;
         memWriteE   <= 1'b0;
         jumpE       <= 1'b0;
         branchE     <= 1'b0;
         aluSrcE     <= 1'b0;
         loadByteE   <= 1'b0;
         resultSrcE  <= riscvPkg::resAlu;
         aluControlE <= riscvPkg::aluAdd;
      end else if (clearNext) begin
         rd1E        <= '0;
         rd2E        <= '0;
         pcE         <= '0;
         pcPlus4E    <= '0;
         immExtE     <= '0;
         rs1E        <= '0;
         rs2E        <= '0;
         rdE         <= '0;
         regWriteE   <= 1'b0;
         memWriteE   <= 1'b0;
         jumpE       <= 1'b0;
         branchE     <= 1'b0;
         aluSrcE     <= 1'b0;
         loadByteE   <= 1'b0;
         resultSrcE  <= riscvPkg::resAlu;
         aluControlE <= riscvPkg::aluAdd;
      end else begin
         rd1E        <= rd1;
         rd2E        <= rd2;
         pcE         <= pc;
         pcPlus4E    <= pcPlus4;
         immExtE     <= immExt;
         rs1E        <= rs1;
         rs2E        <= rs2;
         rdE         <= rd;
         regWriteE   <= ctrl.regWrite;
         memWriteE   <= ctrl.memWrite;
         jumpE       <= ctrl.jump;
         branchE     <= ctrl.branch;
         aluSrcE     <= ctrl.aluSrc;
         loadByteE   <= ctrl.loadByte;
         resultSrcE  <= ctrl.resultSrc;
         aluControlE <= ctrl.aluControl;
      end
   end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
   parameter bit WriteThrough = 1'b1
) (
   input  wire logic                              clk,
   input  wire logic                              rst,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] addr1,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] addr2,
   input  wire logic [riscvPkg::RegAddrWidth-1:0] addr3,
   input  wire logic                              writeEn,
   input  wire logic [riscvPkg::WordWidth-1:0]    writeData,
   output logic [riscvPkg::WordWidth-1:0]         readData1,
   output logic [riscvPkg::WordWidth-1:0]         readData2
);

   localparam int Depth = 2 ** riscvPkg::RegAddrWidth;

   logic [riscvPkg::WordWidth-1:0] regs [Depth];
   logic                           writeLive;

   // x0 never takes a write
   assign writeLive = writeEn && (addr3 != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < Depth; i++) begin
            regs[i] <= '0;
         end
      end else if (writeLive) begin
         regs[addr3] <= writeData;
      end
   end

   // one read port, with optional bypass of the write in flight
   function automatic logic [riscvPkg::WordWidth-1:0] readPort(
      input logic [riscvPkg::RegAddrWidth-1:0] addr
   );
      logic [riscvPkg::WordWidth-1:0] value;
      if (addr == '0) begin
         value = '0;
      end else if (WriteThrough && writeLive && (addr == addr3)) begin
         value = writeData;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   assign readData1 = readPort(addr1);
   assign readData2 = readPort(addr2);

endmodule

`default_nettype wire

/* rtl/immExtender.sv */
`timescale 1ns/1ps
`default_nettype none

module immExtender (
   input  wire logic [riscvPkg::WordWidth-1:0] instr,
   input  riscvPkg::immSrcT                    immSrc,
   output logic [riscvPkg::WordWidth-1:0]      immExt
);

   localparam int W = riscvPkg::WordWidth;

   logic signBit;

   // every format takes its sign from bit 31
   assign signBit = instr[31];

   always_comb begin
      case (immSrc)
         // imm[11:0]
         riscvPkg::immI: immExt = {{(W - 12){signBit}}, instr[31:20]};
         // imm[11:5] and imm[4:0]
         riscvPkg::immS: immExt = {{(W - 12){signBit}}, instr[31:25], instr[11:7]};
         // branch offset, halfword aligned
         riscvPkg::immB: immExt = {{(W - 12){signBit}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
         // jal offset, halfword aligned
         riscvPkg::immJ: immExt = {{(W - 20){signBit}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
         default:        immExt = '0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  wire logic [riscvPkg::WordWidth-1:0] instr,
   ctrlIf.ctrlSrc                             ctrl
);

   // class of ALU operation chosen by the main decoder
   typedef enum logic [1:0] {
      opClassAdd,
      opClassSub,
      opClassFunct
   } aluOpT;

   riscvPkg::opcodeT opcode;
   aluOpT            aluOp;
   logic [2:0]       funct3;
   logic             funct7b5;
   logic             isRtype;

   assign opcode   = riscvPkg::opcodeT'(instr[6:0]);
   assign funct3   = instr[14:12];
   assign funct7b5 = instr[30];
   assign isRtype  = (opcode == riscvPkg::opRtype);

   // main decoder
   always_comb begin
      ctrl.regWrite  = 1'b0;
      ctrl.memWrite  = 1'b0;
      ctrl.branch    = 1'b0;
      ctrl.jump      = 1'b0;
      ctrl.aluSrc    = 1'b0;
      ctrl.resultSrc = riscvPkg::resAlu;
      ctrl.immSrc    = riscvPkg::immI;
      aluOp          = opClassAdd;
      case (opcode)
         riscvPkg::opLoad: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrc    = 1'b1;
            ctrl.resultSrc = riscvPkg::resMem;
         end
         riscvPkg::opStore: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.immSrc   = riscvPkg::immS;
         end
         riscvPkg::opRtype: begin
            ctrl.regWrite = 1'b1;
            aluOp         = opClassFunct;
         end
         riscvPkg::opItype: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            aluOp         = opClassFunct;
         end
         riscvPkg::opBranch: begin
            ctrl.branch = 1'b1;
            ctrl.immSrc = riscvPkg::immB;
            aluOp       = opClassSub;
         end
         riscvPkg::opJal: begin
            ctrl.regWrite  = 1'b1;
            ctrl.jump      = 1'b1;
            ctrl.resultSrc = riscvPkg::resPc4;
            ctrl.immSrc    = riscvPkg::immJ;
         end
         // unknown opcode stays a bubble
         default: ;
      endcase
   end

   // ALU decoder
   always_comb begin
      ctrl.aluControl = riscvPkg::aluAdd;
      case (aluOp)
         opClassSub: ctrl.aluControl = riscvPkg::aluSub;
         opClassFunct: begin
            case (funct3)
               3'b000:  ctrl.aluControl = (isRtype && funct7b5) ? riscvPkg::aluSub
                                                                  : riscvPkg::aluAdd;
               3'b010:  ctrl.aluControl = riscvPkg::aluSlt;
               3'b110:  ctrl.aluControl = riscvPkg::aluOr;
               3'b111:  ctrl.aluControl = riscvPkg::aluAnd;
               default: ctrl.aluControl = riscvPkg::aluAdd;
            endcase
         end
         default: ctrl.aluControl = riscvPkg::aluAdd;
      endcase
   end

   // lb shares the load opcode with lw, funct3 tells them apart
   assign ctrl.loadByte = (opcode == riscvPkg::opLoad) && (funct3 == 3'b000);

endmodule

`default_nettype wire

/* rtl/ctrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

   logic                regWrite;
   logic                memWrite;
   logic                jump;
   logic                branch;
   logic                aluSrc;
   logic                loadByte;
   riscvPkg::resultSrcT resultSrc;
   riscvPkg::aluCtrlT   aluControl;
   riscvPkg::immSrcT    immSrc;

   // decoder side drives the whole bundle
   modport ctrlSrc (
      output regWrite, memWrite, jump, branch, aluSrc, loadByte,
      output resultSrc, aluControl, immSrc
   );

   // pipeline register side, immSrc is consumed in decode only
   modport ctrlDst (
      input regWrite, memWrite, jump, branch, aluSrc, loadByte,
      input resultSrc, aluControl
   );

endinterface

`default_nettype wire

/* rtl/riscvPkg.sv */
`default_nettype none

package riscvPkg;

   // datapath word and register index widths
   localparam int WordWidth    = 32;
   localparam int RegAddrWidth = 5;

   // major opcodes of the supported RV32I subset
   typedef enum logic [6:0] {
      opLoad   = 7'b0000011,
      opStore  = 7'b0100011,
      opRtype  = 7'b0110011,
      opItype  = 7'b0010011,
      opBranch = 7'b1100011,
      opJal    = 7'b1101111
   } opcodeT;

   // execute ALU operation
   // aluAdd is the zero code so a bubble leaves the ALU adding
   typedef enum logic [2:0] {
      aluAdd = 3'b000,
      aluSub = 3'b001,
      aluAnd = 3'b010,
      aluOr  = 3'b011,
      aluSlt = 3'b101
   } aluCtrlT;

   // immediate format selector
   typedef enum logic [1:0] {
      immI = 2'b00,
      immS = 2'b01,
      immB = 2'b10,
      immJ = 2'b11
   } immSrcT;

   // writeback result source
   typedef enum logic [1:0] {
      resAlu = 2'b00,
      resMem = 2'b01,
      resPc4 = 2'b10
   } resultSrcT;

endpackage

`default_nettype wire
